/* burst_dma.f */
+incdir+hdl
hdl/dma_pkg.sv
hdl/dma_apb_regs.sv
hdl/dma_channel_arbiter.sv
hdl/dma_burst_engine.sv
hdl/dma_scratch_mem.sv
hdl/burst_dma_top.sv
bench/burst_dma_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the burst_dma testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal -f burst_dma.f \
    --top-module burst_dma_tb -o burst_dma_sim > build.log 2>&1 \
    && ./obj_dir/burst_dma_sim > sim.log 2>&1 \
    || { echo "Build or run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation finished: FAIL" sim.log \
    && { echo "Test failed"; exit 1; } \
    || { echo "Test passed"; exit 0; }

/* bench/burst_dma_tb.sv */
////////////////////////////////////////
// Burst DMA testbench with APB tasks, LFSR,
// reference memory and copy table
////////////////////////////////////////

`timescale 1ns/10ps
`include "dma_config.svh"

module burst_dma_tb;

    localparam int POLL_LIMIT  = 400;
    localparam int READY_LIMIT = 16;
    localparam int NUM_ROWS    = 7;

    typedef struct packed {
        logic [1:0]  chan;
        logic [31:0] src;
        logic [31:0] dst;
        logic [15:0] count;
        logic        irq_en;
        logic        probe; // Try a descriptor write while started
        logic        last;  // Closes a group started together
    } row_t;

    logic                 clk;
    logic                 rst;
    dma_pkg::apb_req_t    apb_req;
    dma_pkg::apb_rsp_t    apb_rsp;
    logic                 irq;
    logic [31:0]          ref_mem [`DMA_MEM_WORDS];
    logic [31:0]          lfsr_state;
    row_t                 rows [NUM_ROWS];
    int                   errors;
    int                   checks;

    burst_dma_top uut (
        .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp), .irq(irq)
    );

    always #4 clk = ~clk;

    // Galois form shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w = {w[30:0], lfsr_state[0]}; // One step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s, expected %h, got %h", $time, what, exp, got);
        end
    endtask

    // Setup cycle then access cycle held until pready
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.pwrite  <= wr;
        apb_req.pwdata  <= wdata;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready && waits < READY_LIMIT) begin
            waits++;
            @(negedge clk);
        end
        if (!apb_rsp.pready) begin
            fail_now($sformatf("APB transfer to address %h never got pready", addr));
        end else begin
            rdata = apb_rsp.prdata;
            err   = apb_rsp.pslverr;
            @(posedge clk);
            apb_req.psel    <= 1'b0;
            apb_req.penable <= 1'b0;
        end
    endtask

    task automatic reg_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_value($sformatf("pslverr on write to %h", addr), 32'(err), 32'(exp_err));
    endtask

    task automatic reg_read(input logic [11:0] addr, output logic [31:0] data,
                            input logic exp_err);
        logic err;
        apb_xfer(1'b0, addr, 32'h0, data, err);
        check_value($sformatf("pslverr on read of %h", addr), 32'(err), 32'(exp_err));
    endtask

    task automatic mem_write(input logic [`DMA_MEM_AW-1:0] idx, input logic [31:0] data);
        reg_write(`DMA_MEM_BASE + {2'b00, idx, 2'b00}, data, 1'b0);
        ref_mem[idx] = data; // Mirror in the model
    endtask

    task automatic program_desc(input row_t row);
        logic [11:0] base;
        base = {6'h0, row.chan, 4'h0};
        reg_write(base, row.src, 1'b0);
        reg_write(base + 12'h4, row.dst, 1'b0);
        reg_write(base + 12'h8, {16'h0, row.count}, 1'b0);
    endtask

    // Descriptor must not change while the channel is started
    task automatic busy_probe(input row_t row);
        logic [11:0] base;
        logic [31:0] rd;
        base = {6'h0, row.chan, 4'h0};
        reg_write(base, ~row.src, 1'b1);
        reg_read(base, rd, 1'b0);
        check_value("source of a started channel", rd, row.src);
    endtask

    task automatic wait_done(input logic [3:0] mask);
        logic [31:0] st;
        int          polls;
        polls = 0;
        reg_read(`DMA_STATUS_OFS, st, 1'b0);
        while ((st[7:4] & mask) != mask && polls < POLL_LIMIT) begin
            polls++;
            reg_read(`DMA_STATUS_OFS, st, 1'b0);
        end
        if ((st[7:4] & mask) != mask) begin
            fail_now($sformatf("Done bits %b never set, status %h", mask, st));
        end else begin
            check_value("start bits after completion", 32'(st[3:0]), 32'h0);
        end
    endtask

    task automatic model_copy(input row_t row);
        logic [`DMA_MEM_AW-1:0] si;
        logic [`DMA_MEM_AW-1:0] di;
        si = row.src[`DMA_MEM_AW+1:2];
        di = row.dst[`DMA_MEM_AW+1:2];
        for (int k = 0; k < row.count; k++) begin
            ref_mem[di] = ref_mem[si]; // Words in order with wrap modulo memory
            si++;
            di++;
        end
    endtask

    // Destination plus two guard words on each side
    task automatic check_window(input row_t row);
        logic [`DMA_MEM_AW-1:0] idx;
        logic [31:0]            got;
        idx = row.dst[`DMA_MEM_AW+1:2] - 2'd2;
        for (int k = 0; k < row.count + 4; k++) begin
            reg_read(`DMA_MEM_BASE + {2'b00, idx, 2'b00}, got, 1'b0);
            check_value($sformatf("word %0d after channel %0d", idx, row.chan), got, ref_mem[idx]);
            idx++;
        end
    endtask

    initial begin
        logic [31:0] w;
        logic [3:0]  mask;
        logic        exp_irq;
        int          first;
        clk        = 1'b0;
        rst        = 1'b1;
        apb_req    = '0;
        errors     = 0;
        checks     = 0;
        first      = 0;
        lfsr_state = 32'h1084_3399;

        //          chan   src         dst         count   irq   probe last
        rows[0] = '{2'd0, 32'h0000, 32'h0200, 16'd5,  1'b1, 1'b0, 1'b1};
        rows[1] = '{2'd1, 32'h0040, 32'h0280, 16'd20, 1'b0, 1'b0, 1'b1};
        rows[2] = '{2'd2, 32'h00A0, 32'h0300, 16'd6,  1'b1, 1'b0, 1'b0};
        rows[3] = '{2'd1, 32'h00C0, 32'h0320, 16'd9,  1'b0, 1'b0, 1'b0};
        rows[4] = '{2'd3, 32'h0100, 32'h0360, 16'd12, 1'b1, 1'b0, 1'b1};
        rows[5] = '{2'd3, 32'h0140, 32'h03C0, 16'd0,  1'b1, 1'b0, 1'b1};
        rows[6] = '{2'd0, 32'h0160, 32'h0200, 16'd40, 1'b0, 1'b1, 1'b1};

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < `DMA_MEM_WORDS; i++) begin
            rand_word(w);
            mem_write(i[`DMA_MEM_AW-1:0], w);
        end

        // Descriptor readback and error responses
        reg_write(12'h030, 32'h0000_0123, 1'b0);
        reg_write(12'h034, 32'h0000_0456, 1'b0);
        reg_write(12'h038, 32'h0000_0011, 1'b0);
        reg_read(12'h030, w, 1'b0);
        check_value("channel 3 source readback", w, 32'h0000_0123);
        reg_read(12'h034, w, 1'b0);
        check_value("channel 3 destination readback", w, 32'h0000_0456);
        reg_read(12'h038, w, 1'b0);
        check_value("channel 3 count readback", w, 32'h0000_0011);
        reg_read(12'h080, w, 1'b1);
        reg_write(12'h3F0, 32'h0, 1'b1);
        reg_write(`DMA_STATUS_OFS, 32'h1, 1'b1); // Start bits are read-only

        for (int r = 0; r < NUM_ROWS; r++) begin
            program_desc(rows[r]);
            if (rows[r].last) begin
                mask    = '0;
                exp_irq = 1'b0;
                for (int g = first; g <= r; g++) begin
                    reg_write({6'h0, rows[g].chan, 4'hC}, {30'h0, rows[g].irq_en, 1'b1}, 1'b0);
                    mask[rows[g].chan] = 1'b1;
                    exp_irq = exp_irq | rows[g].irq_en;
                end
                for (int g = first; g <= r; g++) begin
                    if (rows[g].probe) begin
                        busy_probe(rows[g]);
                    end
                end
                wait_done(mask);
                for (int g = first; g <= r; g++) begin
                    model_copy(rows[g]);
                end
                for (int g = first; g <= r; g++) begin
                    check_window(rows[g]);
                end
                @(negedge clk);
                check_value("irq after done", 32'(irq), 32'(exp_irq));
                reg_write(`DMA_STATUS_OFS, {24'h0, mask, 4'h0}, 1'b0); // Clear done
                reg_read(`DMA_STATUS_OFS, w, 1'b0);
                check_value("done bits after clear", 32'(w[7:4]), 32'h0);
                @(negedge clk);
                check_value("irq after clear", 32'(irq), 32'h0);
                first = r + 1;
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/burst_dma_top.sv */
////////////////////////////////////////
// Burst DMA top level
////////////////////////////////////////

`timescale 1ns/10ps
`include "dma_config.svh"

module burst_dma_top (
    input  logic              clk,
    input  logic              rst,
    input  dma_pkg::apb_req_t apb_req,
    output dma_pkg::apb_rsp_t apb_rsp,
    output logic              irq
);

    dma_pkg::chan_desc_t [`DMA_CHANNELS-1:0] descs;
    logic [`DMA_CHANNELS-1:0]                pending;
    logic                                    engine_idle;
    logic                                    done_valid;
    dma_pkg::chan_idx_t                      done_chan;
    dma_pkg::grant_t                         grant;
    logic [`DMA_MEM_AW-1:0]                  mem_addr;
    logic [31:0]                             mem_wdata;
    logic                                    mem_we;
    logic [31:0]                             mem_rdata;
    logic [`DMA_MEM_AW-1:0]                  eng_rd_addr;
    logic [31:0]                             eng_rd_data;
    dma_pkg::mem_wr_t                        eng_wr;

    dma_apb_regs u_regs (
        .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp), .descs(descs),
        .pending(pending), .done_valid(done_valid), .done_chan(done_chan), .irq(irq),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_rdata(mem_rdata)
    );

    dma_channel_arbiter u_arb (
        .clk(clk), .rst(rst), .pending(pending), .descs(descs), .engine_idle(engine_idle),
        .done_valid(done_valid), .done_chan(done_chan), .grant(grant)
    );

    dma_burst_engine u_engine (
        .clk(clk), .rst(rst), .grant(grant), .engine_idle(engine_idle), .rd_addr(eng_rd_addr),
        .rd_data(eng_rd_data), .wr(eng_wr), .done_valid(done_valid), .done_chan(done_chan)
    );

    dma_scratch_mem u_mem (
        .clk(clk), .apb_addr(mem_addr), .apb_wdata(mem_wdata), .apb_we(mem_we),
        .apb_rdata(mem_rdata), .eng_rd_addr(eng_rd_addr), .eng_rd_data(eng_rd_data),
        .eng_wr(eng_wr)
    );

endmodule

/* hdl/dma_scratch_mem.sv */
////////////////////////////////////////
// Scratch word memory, APB and
// engine ports
////////////////////////////////////////

`timescale 1ns/10ps
`include "dma_config.svh"

module dma_scratch_mem (
    input  logic                   clk,
    input  logic [`DMA_MEM_AW-1:0] apb_addr,
    input  logic [31:0]            apb_wdata,
    input  logic                   apb_we,
    output logic [31:0]            apb_rdata,
    input  logic [`DMA_MEM_AW-1:0] eng_rd_addr,
    output logic [31:0]            eng_rd_data,
    input  dma_pkg::mem_wr_t       eng_wr
);

    logic [31:0] mem [`DMA_MEM_WORDS];
    logic        apb_collide;

    // Engine owns the word when both write it
    assign apb_collide = eng_wr.en && (eng_wr.addr == apb_addr);

    always_ff @(posedge clk) begin
        if (apb_we && !apb_collide) begin
            mem[apb_addr] <= apb_wdata;
        end
        if (eng_wr.en) begin
            mem[eng_wr.addr] <= eng_wr.data;
        end
    end

    // Both read ports registered, one cycle latency
    always_ff @(posedge clk) begin
        apb_rdata   <= mem[apb_addr];
        eng_rd_data <= mem[eng_rd_addr];
    end

endmodule

/* hdl/dma_burst_engine.sv */
////////////////////////////////////////
// Pipelined copy engine with burst
// pauses and completion report
////////////////////////////////////////

`timescale 1ns/10ps
`include "dma_config.svh"

module dma_burst_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  dma_pkg::grant_t        grant,
    output logic                   engine_idle,
    output logic [`DMA_MEM_AW-1:0] rd_addr,
    input  logic [31:0]            rd_data,
    output dma_pkg::mem_wr_t       wr,
    output logic                   done_valid,
    output dma_pkg::chan_idx_t     done_chan
);

    localparam int BW = $clog2(`DMA_BURST_LEN + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_XFER,
        S_PAUSE,
        S_DRAIN
    } state_t;

    state_t                 state;
    logic [31:0]            src_ptr;
    logic [31:0]            dst_ptr;
    logic [15:0]            remaining;
    logic [BW-1:0]          burst_cnt; // Words issued in current burst
    logic                   wr_valid_q;
    logic [`DMA_MEM_AW-1:0] wr_addr_q;

    assign engine_idle = (state == S_IDLE);

    // Byte address to word index, wraps modulo memory size
    assign rd_addr = src_ptr[`DMA_MEM_AW+1:2];

    // Read data lands one cycle after the read, paired with its index
    assign wr = '{en: wr_valid_q, addr: wr_addr_q, data: rd_data};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            src_ptr    <= '0;
            dst_ptr    <= '0;
            remaining  <= '0;
            burst_cnt  <= '0;
            wr_valid_q <= 1'b0;
            done_valid <= 1'b0;
            done_chan  <= '0;
        end else begin
            done_valid <= 1'b0;
            wr_valid_q <= (state == S_XFER); // A read issued this cycle
            case (state)
                S_IDLE: begin
                    if (grant.valid) begin
                        src_ptr   <= grant.desc.src;
                        dst_ptr   <= grant.desc.dst;
                        remaining <= grant.desc.count;
                        burst_cnt <= '0;
                        done_chan <= grant.chan;
                        if (grant.desc.count == 16'd0) begin
                            done_valid <= 1'b1; // Nothing to copy
                        end else begin
                            state <= S_XFER;
                        end
                    end
                end
                S_XFER: begin
                    src_ptr   <= src_ptr + 32'd4;
                    dst_ptr   <= dst_ptr + 32'd4;
                    remaining <= remaining - 16'd1;
                    if (remaining == 16'd1) begin
                        state <= S_DRAIN; // Last word, no pause after it
                    end else if (burst_cnt == BW'(`DMA_BURST_LEN - 1)) begin
                        burst_cnt <= '0;
                        state     <= S_PAUSE;
                    end else begin
                        burst_cnt <= burst_cnt + 1'b1;
                    end
                end
                S_PAUSE: begin
                    state <= S_XFER;
                end
                S_DRAIN: begin
                    // Final write goes out this cycle
                    state      <= S_IDLE;
                    done_valid <= 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Destination index travels alongside the outstanding read
    always_ff @(posedge clk) begin
        if (state == S_XFER) begin
            wr_addr_q <= dst_ptr[`DMA_MEM_AW+1:2];
        end
    end

endmodule

/* hdl/dma_channel_arbiter.sv */
////////////////////////////////////////
// Fixed-priority channel arbiter
////////////////////////////////////////

`timescale 1ns/10ps
`include "dma_config.svh"

module dma_channel_arbiter (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [`DMA_CHANNELS-1:0]                pending,
    input  dma_pkg::chan_desc_t [`DMA_CHANNELS-1:0] descs,
    input  logic                                    engine_idle,
    input  logic                                    done_valid,
    input  dma_pkg::chan_idx_t                      done_chan,
    output dma_pkg::grant_t                         grant
);

    logic [`DMA_CHANNELS-1:0] granted; // Served, awaiting completion
    logic [`DMA_CHANNELS-1:0] avail;
    logic                     pick_valid;
    dma_pkg::chan_idx_t       pick;

    assign avail = pending & ~granted;

    // Lowest index wins, so scan downward
    always_comb begin
        pick_valid = 1'b0;
        pick       = '0;
        for (int i = `DMA_CHANNELS - 1; i >= 0; i--) begin
            if (avail[i]) begin
                pick_valid = 1'b1;
                pick       = dma_pkg::chan_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            granted <= '0;
            grant   <= '0;
        end else begin
            grant.valid <= 1'b0; // One-cycle grant
            if (done_valid) begin
                granted[done_chan] <= 1'b0;
            end
            if (engine_idle && !grant.valid && pick_valid) begin
                grant.valid    <= 1'b1;
                grant.chan     <= pick;
                grant.desc     <= descs[pick];
                granted[pick]  <= 1'b1;
            end
        end
    end

endmodule

/* hdl/dma_apb_regs.sv */
////////////////////////////////////////
// APB slave: channel descriptors,
// control/status bits, memory window
////////////////////////////////////////

`timescale 1ns/10ps
`include "dma_config.svh"

module dma_apb_regs (
    input  logic                                    clk,
    input  logic                                    rst,
    input  dma_pkg::apb_req_t                       apb_req,
    output dma_pkg::apb_rsp_t                       apb_rsp,
    output dma_pkg::chan_desc_t [`DMA_CHANNELS-1:0] descs,
    output logic [`DMA_CHANNELS-1:0]                pending,
    input  logic                                    done_valid,
    input  dma_pkg::chan_idx_t                      done_chan,
    output logic                                    irq,
    output logic [`DMA_MEM_AW-1:0]                  mem_addr,
    output logic [31:0]                             mem_wdata,
    output logic                                    mem_we,
    input  logic [31:0]                             mem_rdata
);

    localparam int CH = `DMA_CHANNELS;

    logic [CH-1:0]      start;
    logic [CH-1:0]      done;
    logic [CH-1:0]      irq_en;
    logic               mem_wait;  // Second access cycle of a window read
    logic               access;
    logic               is_mem;
    logic               is_chan;
    logic               is_status;
    logic               err;
    logic               wr_ok;
    logic [11:0]        win_ofs;
    dma_pkg::chan_idx_t sel_chan;
    logic [1:0]         reg_sel;

    // Address decode
    assign access    = apb_req.psel && apb_req.penable;
    assign is_mem    = (apb_req.paddr >= `DMA_MEM_BASE) &&
                       (apb_req.paddr < `DMA_MEM_BASE + `DMA_MEM_WORDS * 4);
    assign is_chan   = apb_req.paddr < CH * 16;
    assign is_status = {apb_req.paddr[11:2], 2'b00} == `DMA_STATUS_OFS;
    assign sel_chan  = apb_req.paddr[4 +: $bits(dma_pkg::chan_idx_t)];
    assign reg_sel   = apb_req.paddr[3:2];
    assign win_ofs   = apb_req.paddr - `DMA_MEM_BASE;

    // Unmapped, busy descriptor, or write to the start bits
    assign err = !(is_mem || is_chan || is_status) ||
                 (is_chan && apb_req.pwrite && reg_sel != 2'd3 && start[sel_chan]) ||
                 (is_status && apb_req.pwrite && |apb_req.pwdata[CH-1:0]);

    assign wr_ok = access && apb_req.pwrite && !err; // Writes never wait

    assign apb_rsp.pready  = access && !(is_mem && !apb_req.pwrite && !mem_wait);
    assign apb_rsp.pslverr = apb_rsp.pready && err;

    always_comb begin
        apb_rsp.prdata = '0;
        if (is_mem) begin
            apb_rsp.prdata = mem_rdata;
        end else if (is_status) begin
            apb_rsp.prdata = 32'({done, start});
        end else if (is_chan) begin
            case (reg_sel)
                2'd0: apb_rsp.prdata = descs[sel_chan].src;
                2'd1: apb_rsp.prdata = descs[sel_chan].dst;
                2'd2: apb_rsp.prdata = {16'h0, descs[sel_chan].count};
                default: apb_rsp.prdata = {30'h0, irq_en[sel_chan], start[sel_chan]};
            endcase
        end
    end

    assign mem_addr  = win_ofs[`DMA_MEM_AW+1:2];
    assign mem_wdata = apb_req.pwdata;
    assign mem_we    = wr_ok && is_mem;

    assign pending = start;
    assign irq     = |(done & irq_en);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wait <= 1'b0;
        end else begin
            mem_wait <= access && is_mem && !apb_req.pwrite && !mem_wait;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            descs  <= '0;
            start  <= '0;
            done   <= '0;
            irq_en <= '0;
        end else begin
            if (wr_ok && is_chan) begin
                case (reg_sel)
                    2'd0: descs[sel_chan].src <= apb_req.pwdata;
                    2'd1: descs[sel_chan].dst <= apb_req.pwdata;
                    2'd2: descs[sel_chan].count <= apb_req.pwdata[15:0];
                    default: begin
                        irq_en[sel_chan] <= apb_req.pwdata[1];
                        if (apb_req.pwdata[0] && !start[sel_chan]) begin
                            start[sel_chan] <= 1'b1;
                            done[sel_chan]  <= 1'b0; // New run clears old done
                        end
                    end
                endcase
            end
            if (wr_ok && is_status) begin
                done <= done & ~apb_req.pwdata[2*CH-1:CH]; // Write 1 to clear
            end
            // Completion from the engine
            if (done_valid) begin
                start[done_chan] <= 1'b0;
                done[done_chan]  <= 1'b1;
            end
        end
    end

endmodule

/* hdl/dma_pkg.sv */
////////////////////////////////////////
// Shared types: APB request/response,
// descriptor, memory write and grant
////////////////////////////////////////

`include "dma_config.svh"

package dma_pkg;

    typedef logic [$clog2(`DMA_CHANNELS)-1:0] chan_idx_t;

    // APB master to slave
    typedef struct packed {
        logic [11:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [31:0] src;   // Byte address
        logic [31:0] dst;   // Byte address
        logic [15:0] count; // Words
    } chan_desc_t;

    typedef struct packed {
        logic                   en;
        logic [`DMA_MEM_AW-1:0] addr; // Word index
        logic [31:0]            data;
    } mem_wr_t;

    // Arbiter to engine, descriptor copied at grant time
    typedef struct packed {
        logic       valid;
        chan_idx_t  chan;
        chan_desc_t desc;
    } grant_t;

endpackage

/* hdl/dma_config.svh */
////////////////////////////////////////
// Sizing and register map macros
// for the burst DMA copier
////////////////////////////////////////

`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Channel and burst sizing
`define DMA_CHANNELS 4
`define DMA_BURST_LEN 8

// Scratch memory, 32-bit words
`define DMA_MEM_WORDS 256
`define DMA_MEM_AW 8

// APB register map
`define DMA_STATUS_OFS 12'h040
`define DMA_MEM_BASE 12'h400 // Window spans DMA_MEM_WORDS*4 bytes

`endif
